// File: chimera_ctrl_cfg.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Configuration macros of the control wrapper
// Cluster count, bus widths, register map, bootrom
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CHIMERA_CTRL_CFG_SVH
`define CHIMERA_CTRL_CFG_SVH

// External clusters behind the wrapper
`define CHIMERA_EXT_CLUSTERS 5

// Register bus
`define CHIMERA_ADDR_WIDTH 32
`define CHIMERA_DATA_WIDTH 32

// Top-level control registers
`define CHIMERA_CLK_GATE_OFFSET 32'h0000_0000
`define CHIMERA_BYPASS_OFFSET 32'h0000_0004

// Cluster bootrom window, one word per 4 bytes
`define CHIMERA_BOOTROM_BASE 32'h0000_1000
`define CHIMERA_BOOTROM_WORDS 16

// ROM contents derive from this
`define CHIMERA_BOOTROM_SEED 32'h0000_0297

`endif

// File: chimera_bus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register bus types: request, response and
// decoded request, plus the bootrom contents
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "chimera_ctrl_cfg.svh"

package chimera_bus_pkg;

  typedef logic [`CHIMERA_ADDR_WIDTH-1:0] reg_addr_t;
  typedef logic [`CHIMERA_DATA_WIDTH-1:0] reg_data_t;
  typedef logic [$clog2(`CHIMERA_BOOTROM_WORDS)-1:0] rom_index_t;

  // Plain strobe request, no handshake
  typedef struct packed {
    logic      valid;
    logic      write;
    reg_addr_t addr;
    reg_data_t wdata;
  } reg_req_t;

  typedef struct packed {
    logic      valid;
    logic      error;
    reg_data_t rdata;
  } reg_rsp_t;

  typedef enum logic [1:0] {
    TGT_CLK_GATE = 2'd0,
    TGT_BYPASS   = 2'd1,
    TGT_BOOTROM  = 2'd2,
    TGT_NONE     = 2'd3
  } reg_target_e;

  // Request after the decode stage
  typedef struct packed {
    logic        valid;
    logic        write;
    reg_target_e target;
    rom_index_t  rom_idx;
    reg_data_t   wdata;
  } dec_req_t;

  // Word k of the cluster bootrom
  function automatic reg_data_t boot_word(rom_index_t idx);
    reg_data_t k;
    k = reg_data_t'(idx);
    return (reg_data_t'(`CHIMERA_BOOTROM_SEED) ^ (k << 7)) | k;
  endfunction

endpackage

// File: chimera_cluster_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Per-cluster vector types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "chimera_ctrl_cfg.svh"

package chimera_cluster_pkg;

  // One bit per external cluster, bit 0 is the first cluster.
  // Used for the gate bits, the bypass bits and the gated clocks.
  typedef logic [`CHIMERA_EXT_CLUSTERS-1:0] cluster_mask_t;

endpackage

// File: chimera_reg_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage of the register slave
// Registers the request and classifies its target
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "chimera_ctrl_cfg.svh"

module chimera_reg_decode
  import chimera_bus_pkg::*;
(
  input  logic     soc_clk_i,
  input  logic     rst_n_i,
  input  reg_req_t reg_req_i,
  output dec_req_t dec_req_o
);

  localparam reg_addr_t rom_base_addr = reg_addr_t'(`CHIMERA_BOOTROM_BASE);
  localparam reg_addr_t rom_end_addr =
    reg_addr_t'(`CHIMERA_BOOTROM_BASE + 4 * `CHIMERA_BOOTROM_WORDS);

  reg_addr_t   rom_offset;
  logic        in_rom;
  reg_target_e target;
  dec_req_t    dec_d;
  dec_req_t    dec_q;

  // Byte offset into the bootrom window
  assign rom_offset = reg_req_i.addr - rom_base_addr;
  assign in_rom     = (reg_req_i.addr >= rom_base_addr) && (reg_req_i.addr < rom_end_addr);

  always_comb begin
    if (reg_req_i.addr == reg_addr_t'(`CHIMERA_CLK_GATE_OFFSET)) begin
      target = TGT_CLK_GATE;
    end else if (reg_req_i.addr == reg_addr_t'(`CHIMERA_BYPASS_OFFSET)) begin
      target = TGT_BYPASS;
    end else if (in_rom) begin
      target = TGT_BOOTROM;
    end else begin
      target = TGT_NONE;
    end
  end

  always_comb begin
    dec_d.valid   = reg_req_i.valid;
    dec_d.write   = reg_req_i.write;
    dec_d.target  = target;
    // Word index, byte lanes dropped
    dec_d.rom_idx = rom_offset[2 +: $bits(rom_index_t)];
    dec_d.wdata   = reg_req_i.wdata;
  end

  always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dec_q <= '0;
    end else begin
      dec_q <= dec_d;
    end
  end

  assign dec_req_o = dec_q;

endmodule

// File: chimera_reg_access.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Access stage of the register slave
// Control registers, bootrom lookup, response
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module chimera_reg_access
  import chimera_bus_pkg::*;
  import chimera_cluster_pkg::*;
(
  input  logic          soc_clk_i,
  input  logic          rst_n_i,
  input  dec_req_t      dec_req_i,
  output reg_rsp_t      reg_rsp_o,
  output cluster_mask_t clk_gate_en_o,
  output cluster_mask_t wide_mem_bypass_o
);

  localparam int unsigned mask_width = $bits(cluster_mask_t);

  cluster_mask_t clk_gate_q;
  cluster_mask_t bypass_q;
  cluster_mask_t wdata_mask;
  logic          wr_req;
  logic          clk_gate_we;
  logic          bypass_we;
  reg_data_t     rom_data;
  reg_rsp_t      rsp_d;
  reg_rsp_t      rsp_q;

  assign wr_req      = dec_req_i.valid && dec_req_i.write;
  assign clk_gate_we = wr_req && (dec_req_i.target == TGT_CLK_GATE);
  assign bypass_we   = wr_req && (dec_req_i.target == TGT_BYPASS);

  // Only the low bits carry a cluster each
  assign wdata_mask = dec_req_i.wdata[mask_width-1:0];

  always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      clk_gate_q <= '0;
      bypass_q   <= '0;
    end else begin
      if (clk_gate_we) begin
        clk_gate_q <= wdata_mask;
      end
      if (bypass_we) begin
        bypass_q <= wdata_mask;
      end
    end
  end

  // ROM is a pure function of the index
  assign rom_data = boot_word(dec_req_i.rom_idx);

  // Read data and error
  always_comb begin
    rsp_d       = '0;
    rsp_d.valid = dec_req_i.valid;
    if (dec_req_i.valid) begin
      unique case (dec_req_i.target)
        TGT_CLK_GATE: begin
          if (!dec_req_i.write) begin
            rsp_d.rdata = reg_data_t'(clk_gate_q);
          end
        end
        TGT_BYPASS: begin
          if (!dec_req_i.write) begin
            rsp_d.rdata = reg_data_t'(bypass_q);
          end
        end
        TGT_BOOTROM: begin
          // Read-only window
          if (dec_req_i.write) begin
            rsp_d.error = 1'b1;
          end else begin
            rsp_d.rdata = rom_data;
          end
        end
        default: begin
          rsp_d.error = 1'b1;
        end
      endcase
    end
  end

  // Response goes out one cycle after decode, for one cycle only
  always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_q <= '0;
    end else begin
      rsp_q <= rsp_d;
    end
  end

  assign reg_rsp_o         = rsp_q;
  assign clk_gate_en_o     = clk_gate_q;
  assign wide_mem_bypass_o = bypass_q;

endmodule

// File: chimera_cluster_clk_gate.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Latch-based clock gates, one per cluster
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module chimera_cluster_clk_gate
  import chimera_cluster_pkg::*;
(
  input  logic          clu_clk_i,
  input  logic          rst_n_i,
  input  cluster_mask_t gate_en_i,
  output cluster_mask_t clu_clk_o
);

  for (genvar i = 0; i < $bits(cluster_mask_t); i++) begin : gen_clk_gates
    logic clk_en_q;

    // Transparent while clock low, so the AND never glitches.
    // Gate bit comes from soc_clk_i; the latch takes the crossing.
    always_latch begin
      if (!rst_n_i) begin
        clk_en_q <= 1'b1;
      end else if (!clu_clk_i) begin
        clk_en_q <= ~gate_en_i[i];
      end
    end

    assign clu_clk_o[i] = clu_clk_i & clk_en_q;
  end

endmodule

// File: chimera_ctrl_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control side of the cluster wrapper
// Two-stage register slave and cluster clock gates
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module chimera_ctrl_top
  import chimera_bus_pkg::*;
  import chimera_cluster_pkg::*;
(
  input  logic          soc_clk_i,
  input  logic          clu_clk_i,
  input  logic          rst_n_i,
  input  reg_req_t      reg_req_i,
  output reg_rsp_t      reg_rsp_o,
  output cluster_mask_t wide_mem_bypass_o,
  output cluster_mask_t clu_clk_o
);

  dec_req_t      dec_req;
  cluster_mask_t clk_gate_en;

  // Stage 1
  chimera_reg_decode i_reg_decode (
    .soc_clk_i(soc_clk_i),
    .rst_n_i  (rst_n_i),
    .reg_req_i(reg_req_i),
    .dec_req_o(dec_req)
  );

  // Stage 2
  chimera_reg_access i_reg_access (
    .soc_clk_i        (soc_clk_i),
    .rst_n_i          (rst_n_i),
    .dec_req_i        (dec_req),
    .reg_rsp_o        (reg_rsp_o),
    .clk_gate_en_o    (clk_gate_en),
    .wide_mem_bypass_o(wide_mem_bypass_o)
  );

  // Gates run on the shared cluster clock
  chimera_cluster_clk_gate i_cluster_clk_gate (
    .clu_clk_i(clu_clk_i),
    .rst_n_i  (rst_n_i),
    .gate_en_i(clk_gate_en),
    .clu_clk_o(clu_clk_o)
  );

endmodule

// File: tb_chimera_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the cluster control wrapper
// Clocks, reset, bus stimulus, response model,
// concurrent checks, watchdog and reporting
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "chimera_ctrl_cfg.svh"

module tb_chimera_ctrl
  import chimera_bus_pkg::*;
  import chimera_cluster_pkg::*;
();

  localparam int unsigned clk_period   = 100;
  localparam int unsigned reset_cycles = 16;
  localparam int unsigned drain_limit  = 16;
  // Cycle budgets of the five tests
  localparam int unsigned budget_cycles = 40 + 120 + 40 + 40 + 80;
  localparam int unsigned margin_cycles = 100;
  localparam int unsigned watchdog_ns =
    (reset_cycles + budget_cycles + margin_cycles) * clk_period;

  localparam reg_addr_t gate_addr   = reg_addr_t'(`CHIMERA_CLK_GATE_OFFSET);
  localparam reg_addr_t bypass_addr = reg_addr_t'(`CHIMERA_BYPASS_OFFSET);
  localparam reg_addr_t rom_base    = reg_addr_t'(`CHIMERA_BOOTROM_BASE);
  localparam reg_addr_t rom_end     =
    reg_addr_t'(`CHIMERA_BOOTROM_BASE + 4 * `CHIMERA_BOOTROM_WORDS);
  localparam cluster_mask_t all_clusters = '1;

  logic          soc_clk;
  logic          clu_clk;
  logic          rst_n;
  reg_req_t      reg_req;
  reg_rsp_t      reg_rsp;
  cluster_mask_t bypass;
  cluster_mask_t clu_clk_gated;

  // Expected responses in request order
  reg_rsp_t      exp_q[$];
  reg_rsp_t      exp_head;
  logic          head_valid;
  cluster_mask_t gate_model;
  cluster_mask_t bypass_model;
  int            error_count = 0;
  int            test_count = 0;
  int            test_err_start = 0;

  logic          req_valid;
  logic          req_bypass_wr;
  cluster_mask_t req_wmask;

  chimera_ctrl_top i_chimera_ctrl_top (
    .soc_clk_i        (soc_clk),
    .clu_clk_i        (clu_clk),
    .rst_n_i          (rst_n),
    .reg_req_i        (reg_req),
    .reg_rsp_o        (reg_rsp),
    .wide_mem_bypass_o(bypass),
    .clu_clk_o        (clu_clk_gated)
  );

  initial begin
    soc_clk = 1'b0;
    forever #(clk_period / 2) soc_clk = ~soc_clk;
  end

  // Cluster clock lags the SoC clock by a quarter period
  initial begin
    clu_clk = 1'b0;
    #25;
    forever #(clk_period / 2) clu_clk = ~clu_clk;
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns, the run did not finish", watchdog_ns);
    $display("tests failed");
    $finish;
  end

  // Index flips seed bits 10:7 and is ORed into bits 3:0
  function automatic reg_data_t expected_rom_word(input int k);
    reg_data_t  seed;
    logic [3:0] kb;
    seed = reg_data_t'(`CHIMERA_BOOTROM_SEED);
    kb   = k[3:0];
    return {seed[31:11], seed[10:7] ^ kb, seed[6:4], seed[3:0] | kb};
  endfunction

  // Next response moves to the head while it is on the bus
  always @(negedge soc_clk) begin
    if (reg_rsp.valid) begin
      if (exp_q.size() != 0) begin
        exp_head   = exp_q.pop_front();
        head_valid = 1'b1;
      end else begin
        head_valid = 1'b0;
      end
    end
  end

  assign req_valid     = reg_req.valid;
  assign req_bypass_wr = reg_req.valid && reg_req.write && (reg_req.addr == bypass_addr);
  assign req_wmask     = reg_req.wdata[`CHIMERA_EXT_CLUSTERS-1:0];

  rsp_latency: assert property (
    @(posedge soc_clk) disable iff (!rst_n) req_valid |-> ##2 reg_rsp.valid
  ) else begin
    $display("FAILED %0t: no response two cycles after a request", $time);
    error_count++;
  end

  rsp_no_spurious: assert property (
    @(posedge soc_clk) disable iff (!rst_n) reg_rsp.valid |-> $past(req_valid, 2)
  ) else begin
    $display("FAILED %0t: response without a request two cycles before", $time);
    error_count++;
  end

  rsp_value: assert property (
    @(posedge soc_clk) disable iff (!rst_n)
      reg_rsp.valid |-> (head_valid && (reg_rsp == exp_head))
  ) else begin
    $display("FAILED %0t: response %h, expected %h", $time, $sampled(reg_rsp), exp_head);
    error_count++;
  end

  bypass_follow: assert property (
    @(posedge soc_clk) disable iff (!rst_n)
      req_bypass_wr |-> ##2 (bypass == $past(req_wmask, 2))
  ) else begin
    $display("FAILED %0t: bypass output %b does not follow the write", $time,
             $sampled(bypass));
    error_count++;
  end

  // Drives one request and predicts its response
  task automatic send_req(input logic write, input reg_addr_t addr, input reg_data_t wdata);
    reg_rsp_t exp;
    @(posedge soc_clk);
    #10;
    reg_req.valid = 1'b1;
    reg_req.write = write;
    reg_req.addr  = addr;
    reg_req.wdata = wdata;
    exp       = '0;
    exp.valid = 1'b1;
    if (addr == gate_addr) begin
      if (write) begin
        gate_model = wdata[`CHIMERA_EXT_CLUSTERS-1:0];
      end else begin
        exp.rdata = reg_data_t'(gate_model);
      end
    end else if (addr == bypass_addr) begin
      if (write) begin
        bypass_model = wdata[`CHIMERA_EXT_CLUSTERS-1:0];
      end else begin
        exp.rdata = reg_data_t'(bypass_model);
      end
    end else if (addr >= rom_base && addr < rom_end) begin
      if (write) begin
        exp.error = 1'b1;
      end else begin
        exp.rdata = expected_rom_word(int'((addr - rom_base) >> 2));
      end
    end else begin
      exp.error = 1'b1;
    end
    exp_q.push_back(exp);
  endtask

  task automatic bus_idle();
    @(posedge soc_clk);
    #10;
    reg_req = '0;
  endtask

  task automatic drain_responses();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < drain_limit) begin
      @(posedge soc_clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("Responses missing: %0d requests got no answer within %0d cycles",
               exp_q.size(), drain_limit);
      error_count++;
      exp_q.delete();
    end
    // Last check runs on this edge
    @(posedge soc_clk);
    #10;
  endtask

  task automatic sample_cluster_clocks(input int periods, output cluster_mask_t high_seen,
                                       output cluster_mask_t low_seen);
    high_seen = '0;
    low_seen  = '0;
    repeat (periods) begin
      @(posedge clu_clk);
      #10;
      high_seen = high_seen | clu_clk_gated;
      @(negedge clu_clk);
      #10;
      low_seen = low_seen | ~clu_clk_gated;
    end
  endtask

  task automatic check_cluster_clocks(input cluster_mask_t running,
                                      input cluster_mask_t high_seen,
                                      input cluster_mask_t low_seen);
    assert (high_seen == running) else begin
      $display("FAILED %0t: clocks with a high phase %b, expected %b", $time, high_seen,
               running);
      error_count++;
    end
    assert (low_seen == all_clusters) else begin
      $display("FAILED %0t: clocks with a low phase %b, expected all", $time, low_seen);
      error_count++;
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = error_count - test_err_start;
    test_count++;
    if (errs == 0) begin
      $display("test %0d %s: ok", test_count, name);
    end else begin
      $display("test %0d %s: %0d errors", test_count, name, errs);
    end
    test_err_start = error_count;
  endtask

  initial begin
    cluster_mask_t high_seen;
    cluster_mask_t low_seen;
    cluster_mask_t mask;
    reg_addr_t     addr;
    reg_data_t     data;
    int            idx;

    void'($urandom(32'h8bcf_0dc9));
    rst_n        = 1'b0;
    reg_req      = '0;
    exp_head     = '0;
    head_valid   = 1'b0;
    gate_model   = '0;
    bypass_model = '0;
    repeat (reset_cycles) @(posedge soc_clk);
    #10;
    rst_n = 1'b1;

    send_req(1'b0, gate_addr, '0);
    send_req(1'b0, bypass_addr, '0);
    bus_idle();
    drain_responses();
    assert (bypass == '0) else begin
      $display("FAILED %0t: bypass output %b after reset", $time, bypass);
      error_count++;
    end
    sample_cluster_clocks(4, high_seen, low_seen);
    check_cluster_clocks(all_clusters, high_seen, low_seen);
    end_test("reset defaults");

    repeat (8) begin
      data = $urandom;
      send_req(1'b1, bypass_addr, data);
      send_req(1'b0, bypass_addr, '0);
      bus_idle();
      drain_responses();
    end
    end_test("bypass register");

    // Bootrom words on consecutive cycles
    for (int k = 0; k < `CHIMERA_BOOTROM_WORDS; k++) begin
      send_req(1'b0, rom_base + reg_addr_t'(4 * k), '0);
    end
    bus_idle();
    drain_responses();
    end_test("bootrom reads");

    idx  = int'($urandom % `CHIMERA_BOOTROM_WORDS);
    send_req(1'b1, rom_base + reg_addr_t'(4 * idx), $urandom);
    addr = $urandom;
    if (addr == gate_addr || addr == bypass_addr || (addr >= rom_base && addr < rom_end)) begin
      addr = addr | 32'h8000_0000;
    end
    send_req(1'b0, addr, '0);
    send_req(1'b1, addr, $urandom);
    send_req(1'b0, gate_addr, '0);
    send_req(1'b0, bypass_addr, '0);
    bus_idle();
    drain_responses();
    end_test("error accesses");

    mask = cluster_mask_t'(($urandom % 30) + 1);
    send_req(1'b1, gate_addr, reg_data_t'(mask));
    send_req(1'b0, gate_addr, '0);
    bus_idle();
    drain_responses();
    @(posedge clu_clk);
    sample_cluster_clocks(6, high_seen, low_seen);
    check_cluster_clocks(~mask, high_seen, low_seen);
    send_req(1'b1, gate_addr, '0);
    bus_idle();
    drain_responses();
    @(posedge clu_clk);
    sample_cluster_clocks(6, high_seen, low_seen);
    check_cluster_clocks(all_clusters, high_seen, low_seen);
    end_test("clock gating");

    $display("%0d tests run, %0d errors", test_count, error_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+.
chimera_bus_pkg.sv
chimera_cluster_pkg.sv
chimera_reg_decode.sv
chimera_reg_access.sv
chimera_cluster_clk_gate.sv
chimera_ctrl_top.sv
tb_chimera_ctrl.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

log=sim.log
fail_msg="tests failed"

verilator --binary --timing --assert -f tb.f --top-module tb_chimera_ctrl \
  -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build did not succeed"
  exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "$fail_msg" "$log"; then
  echo "Simulation reported failures, see $log"
  exit 1
fi

echo "Simulation clean, see $log"
exit 0
